// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module soc_ifc_top

sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_soc_ifc
	./obj_dir/Vtb_soc_ifc | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/mbox.sv
`timescale 1ns/1ns
`include "soc_ifc_config.svh"

module mbox
    import mbox_pkg::*;
(
    input  logic                        clk,
    input  logic                        cptra_noncore_rst_b,
    input  logic                        req_dv_i,
    input  logic                        req_write_i,
    input  logic [7:0]                  req_addr_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  req_wdata_i,
    output logic [`SOC_IFC_DATA_W-1:0]  rdata_o,
    output logic                        err_o,
    output logic                        data_avail_o
);

    localparam logic [`MBOX_PTR_W:0] DEPTH = `MBOX_DEPTH;

    mbox_state_e                 state_q;
    logic [`SOC_IFC_DATA_W-1:0]  mem [`MBOX_DEPTH];
    logic [`SOC_IFC_DATA_W-1:0]  cmd_q;
    logic [`MBOX_PTR_W-1:0]      wr_ptr_q;
    logic [`MBOX_PTR_W-1:0]      rd_ptr_q;
    logic [`MBOX_PTR_W:0]        count_q;
    logic                        ok;
    logic                        acc;
    logic                        locked;
    logic                        lock_rd;
    logic                        cmd_wr;
    logic                        push;
    logic                        pop;
    logic                        exec_wr;

    assign locked = (state_q != MBOX_IDLE);

    // Everything but a lock read fails while idle
    always_comb begin
        ok      = 1'b0;
        rdata_o = '0;
        case (req_addr_i)
            MBOX_LOCK: begin
                ok         = ~req_write_i;
                rdata_o[0] = locked;
            end
            MBOX_CMD: begin
                ok      = req_write_i ? (state_q == MBOX_RDY_FOR_DATA) : locked;
                rdata_o = cmd_q;
            end
            MBOX_DATAIN: begin
                ok = req_write_i & (state_q == MBOX_RDY_FOR_DATA) & (count_q != DEPTH);
            end
            MBOX_DATAOUT: begin
                ok      = ~req_write_i & (state_q == MBOX_EXECUTING) & (count_q != '0);
                rdata_o = mem[rd_ptr_q];
            end
            MBOX_EXECUTE: begin
                ok         = locked;
                rdata_o[0] = (state_q == MBOX_EXECUTING);
            end
            default: ok = 1'b0;
        endcase
    end

    assign err_o   = req_dv_i & ~ok;
    assign acc     = req_dv_i & ok;
    assign lock_rd = acc & (req_addr_i == MBOX_LOCK) & ~locked;
    assign cmd_wr  = acc & req_write_i & (req_addr_i == MBOX_CMD);
    assign push    = acc & (req_addr_i == MBOX_DATAIN);
    assign pop     = acc & (req_addr_i == MBOX_DATAOUT);
    assign exec_wr = acc & req_write_i & (req_addr_i == MBOX_EXECUTE);

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            state_q      <= MBOX_IDLE;
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            count_q      <= '0;
            data_avail_o <= 1'b0;
        end else begin
            // One cycle behind the state change
            data_avail_o <= (state_q == MBOX_EXECUTING);
            if (lock_rd) begin
                state_q <= MBOX_RDY_FOR_DATA;
            end
            if (exec_wr) begin
                if (req_wdata_i[0]) begin
                    state_q <= MBOX_EXECUTING;
                end else begin
                    // Release lock and drop any leftover words
                    state_q  <= MBOX_IDLE;
                    wr_ptr_q <= '0;
                    rd_ptr_q <= '0;
                    count_q  <= '0;
                end
            end
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
                count_q  <= count_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                count_q  <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            cmd_q <= req_wdata_i;
        end
        if (push) begin
            mem[wr_ptr_q] <= req_wdata_i;
        end
    end

endmodule

// File: hw/mbox_pkg.sv
package mbox_pkg;

    // Lock protocol states
    typedef enum logic [1:0] {
        MBOX_IDLE         = 2'd0,
        MBOX_RDY_FOR_DATA = 2'd1,
        MBOX_EXECUTING    = 2'd2
    } mbox_state_e;

    // Byte offsets inside the mailbox region
    typedef enum logic [7:0] {
        MBOX_LOCK    = 8'h00,
        MBOX_CMD     = 8'h04,
        MBOX_DATAIN  = 8'h08,
        MBOX_DATAOUT = 8'h0C,
        MBOX_EXECUTE = 8'h10
    } mbox_reg_e;

endpackage

// File: hw/soc_ifc_apb_slv.sv
`timescale 1ns/1ns
`include "soc_ifc_config.svh"

module soc_ifc_apb_slv (
    input  logic                        clk,
    input  logic                        cptra_noncore_rst_b,
    input  logic [`SOC_IFC_ADDR_W-1:0]  paddr_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  pwdata_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  reg_rdata_i,
    input  logic                        reg_err_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  mbox_rdata_i,
    input  logic                        mbox_err_i,
    output logic                        pready_o,
    output logic [`SOC_IFC_DATA_W-1:0]  prdata_o,
    output logic                        pslverr_o,
    output logic                        reg_req_dv_o,
    output logic                        mbox_req_dv_o,
    output logic                        req_write_o,
    output logic [7:0]                  req_addr_o,
    output logic [`SOC_IFC_DATA_W-1:0]  req_wdata_o
);

    logic                        access_q;
    logic                        xfer;
    logic                        mbox_sel;
    logic                        range_err;
    logic [`SOC_IFC_ADDR_W-1:0]  region_off;

    // Setup phase seen last cycle, so this cycle is the access phase
    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            access_q <= 1'b0;
        end else begin
            access_q <= psel_i & ~penable_i;
        end
    end

    assign pready_o = access_q;
    assign xfer     = access_q & psel_i & penable_i;

    // Anything above the low byte of a region is unmapped
    assign mbox_sel   = paddr_i[8];
    assign region_off = paddr_i - (mbox_sel ? `MBOX_BASE : `SOC_IFC_REG_BASE);
    assign range_err  = |region_off[`SOC_IFC_ADDR_W-1:8];

    assign reg_req_dv_o  = xfer & ~mbox_sel & ~range_err;
    assign mbox_req_dv_o = xfer & mbox_sel & ~range_err;
    assign req_write_o   = pwrite_i;
    assign req_addr_o    = region_off[7:0];
    assign req_wdata_o   = pwdata_i;

    // Response mux
    assign prdata_o  = mbox_sel ? mbox_rdata_i : reg_rdata_i;
    assign pslverr_o = xfer & (range_err | (mbox_sel ? mbox_err_i : reg_err_i));

endmodule

// File: hw/soc_ifc_boot_fsm.sv
`timescale 1ns/1ns

module soc_ifc_boot_fsm
    import soc_ifc_pkg::*;
(
    input  logic         clk,
    input  logic         cptra_noncore_rst_b,
    input  logic         fuse_done_i,
    input  logic         fw_update_rst_i,
    input  logic         timer_done_i,
    output boot_state_e  boot_state_o,
    output logic         ready_for_fuses_o,
    output logic         cptra_uc_rst_b_o
);

    boot_state_e state_q;
    boot_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Single cycle after reset release
            BOOT_IDLE: state_d = BOOT_FUSE;
            BOOT_FUSE: begin
                if (fuse_done_i) begin
                    state_d = BOOT_DONE;
                end
            end
            BOOT_DONE: begin
                if (fw_update_rst_i) begin
                    state_d = BOOT_FW_RST;
                end
            end
            // Hold core in reset until the wait timer expires
            BOOT_FW_RST: begin
                if (timer_done_i) begin
                    state_d = BOOT_DONE;
                end
            end
            default: state_d = BOOT_IDLE;
        endcase
    end

    // Outputs decoded from next state so they flip together with the state
    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            state_q           <= BOOT_IDLE;
            ready_for_fuses_o <= 1'b0;
            cptra_uc_rst_b_o  <= 1'b0;
        end else begin
            state_q           <= state_d;
            ready_for_fuses_o <= (state_d == BOOT_FUSE);
            cptra_uc_rst_b_o  <= (state_d == BOOT_DONE);
        end
    end

    assign boot_state_o = state_q;

endmodule

// File: hw/soc_ifc_config.svh
`ifndef SOC_IFC_CONFIG_SVH
`define SOC_IFC_CONFIG_SVH

// Bus widths
`define SOC_IFC_DATA_W 32
`define SOC_IFC_ADDR_W 12

// Address bit 8 picks the mailbox region
`define SOC_IFC_REG_BASE 12'h000
`define MBOX_BASE 12'h100

// Mailbox storage
`define MBOX_DEPTH 16
`define MBOX_PTR_W 4

`endif

// File: hw/soc_ifc_pkg.sv
package soc_ifc_pkg;

    // Boot sequencer states, also visible through BOOT_STATUS
    typedef enum logic [2:0] {
        BOOT_IDLE   = 3'd0,
        BOOT_FUSE   = 3'd1,
        BOOT_DONE   = 3'd2,
        BOOT_FW_RST = 3'd3
    } boot_state_e;

    // Byte offsets inside the register region
    typedef enum logic [7:0] {
        FLOW_STATUS     = 8'h00,
        FUSE_DONE       = 8'h04,
        FW_UPDATE_RESET = 8'h08,
        FW_UPDATE_WAIT  = 8'h0C,
        GENERIC_OUT     = 8'h10,
        GENERIC_IN      = 8'h14,
        BOOT_STATUS     = 8'h18
    } soc_ifc_reg_e;

endpackage

// File: hw/soc_ifc_regs.sv
`timescale 1ns/1ns
`include "soc_ifc_config.svh"

module soc_ifc_regs
    import soc_ifc_pkg::*;
(
    input  logic                        clk,
    input  logic                        cptra_noncore_rst_b,
    input  logic                        req_dv_i,
    input  logic                        req_write_i,
    input  logic [7:0]                  req_addr_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  req_wdata_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  generic_in_i,
    input  boot_state_e                 boot_state_i,
    output logic [`SOC_IFC_DATA_W-1:0]  rdata_o,
    output logic                        err_o,
    output logic                        fuse_done_o,
    output logic                        fw_update_rst_o,
    output logic [7:0]                  wait_cycles_o,
    output logic                        ready_for_fw_push_o,
    output logic                        ready_for_runtime_o,
    output logic [`SOC_IFC_DATA_W-1:0]  generic_out_o
);

    logic [1:0]                  flow_q;
    logic                        fuse_done_q;
    logic                        fw_rst_q;
    logic [7:0]                  wait_q;
    logic [`SOC_IFC_DATA_W-1:0]  generic_out_q;
    logic                        hit;
    logic                        ro;
    logic                        wr_en;

    // Read mux and offset decode
    always_comb begin
        hit     = 1'b1;
        ro      = 1'b0;
        rdata_o = '0;
        case (req_addr_i)
            FLOW_STATUS:     rdata_o[1:0] = flow_q;
            FUSE_DONE:       rdata_o[0]   = fuse_done_q;
            FW_UPDATE_RESET: rdata_o      = '0;
            FW_UPDATE_WAIT:  rdata_o[7:0] = wait_q;
            GENERIC_OUT:     rdata_o      = generic_out_q;
            GENERIC_IN: begin
                rdata_o = generic_in_i;
                ro      = 1'b1;
            end
            BOOT_STATUS: begin
                rdata_o[2:0] = boot_state_i;
                ro           = 1'b1;
            end
            default: hit = 1'b0;
        endcase
    end

    assign err_o = req_dv_i & (~hit | (req_write_i & ro));
    assign wr_en = req_dv_i & req_write_i & ~err_o;

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            flow_q        <= 2'b00;
            fuse_done_q   <= 1'b0;
            fw_rst_q      <= 1'b0;
            wait_q        <= 8'd5;
            generic_out_q <= '0;
        end else begin
            fw_rst_q <= 1'b0;
            if (wr_en) begin
                case (req_addr_i)
                    FLOW_STATUS:     flow_q        <= req_wdata_i[1:0];
                    FUSE_DONE:       fuse_done_q   <= fuse_done_q | req_wdata_i[0];
                    // Only honored once the core is running
                    FW_UPDATE_RESET: fw_rst_q      <= req_wdata_i[0] & (boot_state_i == BOOT_DONE);
                    FW_UPDATE_WAIT:  wait_q        <= req_wdata_i[7:0];
                    GENERIC_OUT:     generic_out_q <= req_wdata_i;
                    default: ;
                endcase
            end
        end
    end

    assign fuse_done_o         = fuse_done_q;
    assign fw_update_rst_o     = fw_rst_q;
    assign wait_cycles_o       = wait_q;
    assign ready_for_fw_push_o = flow_q[0];
    assign ready_for_runtime_o = flow_q[1];
    assign generic_out_o       = generic_out_q;

endmodule

// File: hw/soc_ifc_top.sv
`timescale 1ns/1ns
`include "soc_ifc_config.svh"

module soc_ifc_top
    import soc_ifc_pkg::*;
(
    input  logic                        clk,
    input  logic                        cptra_noncore_rst_b,
    input  logic [`SOC_IFC_ADDR_W-1:0]  paddr_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  pwdata_i,
    output logic                        pready_o,
    output logic [`SOC_IFC_DATA_W-1:0]  prdata_o,
    output logic                        pslverr_o,
    input  logic [`SOC_IFC_DATA_W-1:0]  generic_in_i,
    output logic [`SOC_IFC_DATA_W-1:0]  generic_out_o,
    output logic                        ready_for_fuses_o,
    output logic                        ready_for_fw_push_o,
    output logic                        ready_for_runtime_o,
    output logic                        mailbox_data_avail_o,
    output logic                        cptra_uc_rst_b_o
);

    // Request path from the APB slave
    logic                        reg_req_dv;
    logic                        mbox_req_dv;
    logic                        req_write;
    logic [7:0]                  req_addr;
    logic [`SOC_IFC_DATA_W-1:0]  req_wdata;

    // Responses
    logic [`SOC_IFC_DATA_W-1:0]  reg_rdata;
    logic                        reg_err;
    logic [`SOC_IFC_DATA_W-1:0]  mbox_rdata;
    logic                        mbox_err;

    // Boot control
    logic                        fuse_done;
    logic                        fw_update_rst;
    logic [7:0]                  wait_cycles;
    logic                        timer_done;
    boot_state_e                 boot_state;

    soc_ifc_apb_slv i_soc_ifc_apb_slv (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .paddr_i             (paddr_i),
        .psel_i              (psel_i),
        .penable_i           (penable_i),
        .pwrite_i            (pwrite_i),
        .pwdata_i            (pwdata_i),
        .reg_rdata_i         (reg_rdata),
        .reg_err_i           (reg_err),
        .mbox_rdata_i        (mbox_rdata),
        .mbox_err_i          (mbox_err),
        .pready_o            (pready_o),
        .prdata_o            (prdata_o),
        .pslverr_o           (pslverr_o),
        .reg_req_dv_o        (reg_req_dv),
        .mbox_req_dv_o       (mbox_req_dv),
        .req_write_o         (req_write),
        .req_addr_o          (req_addr),
        .req_wdata_o         (req_wdata)
    );

    soc_ifc_regs i_soc_ifc_regs (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .req_dv_i            (reg_req_dv),
        .req_write_i         (req_write),
        .req_addr_i          (req_addr),
        .req_wdata_i         (req_wdata),
        .generic_in_i        (generic_in_i),
        .boot_state_i        (boot_state),
        .rdata_o             (reg_rdata),
        .err_o               (reg_err),
        .fuse_done_o         (fuse_done),
        .fw_update_rst_o     (fw_update_rst),
        .wait_cycles_o       (wait_cycles),
        .ready_for_fw_push_o (ready_for_fw_push_o),
        .ready_for_runtime_o (ready_for_runtime_o),
        .generic_out_o       (generic_out_o)
    );

    soc_ifc_wait_timer i_soc_ifc_wait_timer (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .start_i             (fw_update_rst),
        .count_i             (wait_cycles),
        .done_o              (timer_done)
    );

    soc_ifc_boot_fsm i_soc_ifc_boot_fsm (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .fuse_done_i         (fuse_done),
        .fw_update_rst_i     (fw_update_rst),
        .timer_done_i        (timer_done),
        .boot_state_o        (boot_state),
        .ready_for_fuses_o   (ready_for_fuses_o),
        .cptra_uc_rst_b_o    (cptra_uc_rst_b_o)
    );

    mbox i_mbox (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .req_dv_i            (mbox_req_dv),
        .req_write_i         (req_write),
        .req_addr_i          (req_addr),
        .req_wdata_i         (req_wdata),
        .rdata_o             (mbox_rdata),
        .err_o               (mbox_err),
        .data_avail_o        (mailbox_data_avail_o)
    );

endmodule

// File: hw/soc_ifc_wait_timer.sv
`timescale 1ns/1ns

module soc_ifc_wait_timer (
    input  logic        clk,
    input  logic        cptra_noncore_rst_b,
    input  logic        start_i,
    input  logic [7:0]  count_i,
    output logic        done_o
);

    logic [7:0] count_q;
    logic       running_q;

    assign done_o = running_q & (count_q == 8'd0);

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            count_q   <= 8'd0;
            running_q <= 1'b0;
        end else if (start_i) begin
            count_q   <= count_i;
            running_q <= 1'b1;
        end else if (done_o) begin
            // Stop after the single done cycle
            running_q <= 1'b0;
        end else if (running_q) begin
            count_q <= count_q - 1'b1;
        end
    end

endmodule

// File: sim.f
+incdir+hw
hw/soc_ifc_pkg.sv
hw/mbox_pkg.sv
hw/soc_ifc_apb_slv.sv
hw/soc_ifc_wait_timer.sv
hw/soc_ifc_boot_fsm.sv
hw/soc_ifc_regs.sv
hw/mbox.sv
hw/soc_ifc_top.sv
tb/soc_ifc_tb_clk.sv
tb/tb_soc_ifc.sv

// File: tb/soc_ifc_cases.txt
# op addr wdata exp_rdata exp_err, all hex
# read data is compared only on reads that expect no error
R 00c 00000000 00000005 0
R 000 00000000 00000000 0
W 000 00000001 00000000 0
R 000 00000000 00000001 0
W 000 00000003 00000000 0
R 000 00000000 00000003 0
W 010 a5c3f00d 00000000 0
R 010 00000000 a5c3f00d 0
W 00c 00000011 00000000 0
R 00c 00000000 00000011 0
R 004 00000000 00000001 0
R 008 00000000 00000000 0
R 018 00000000 00000002 0
W 018 00000007 00000000 1
R 018 00000000 00000002 0
W 01c 00000001 00000000 1
R 01c 00000000 00000000 1
W 210 ffffffff 00000000 1
W 014 00000000 00000000 1
R 010 00000000 a5c3f00d 0

// File: tb/soc_ifc_tb_clk.sv
`timescale 1ns/1ns

module soc_ifc_tb_clk (
    output logic clk_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

endmodule

// File: tb/tb_soc_ifc.sv
`timescale 1ns/1ns
`include "soc_ifc_config.svh"

module tb_soc_ifc
    import soc_ifc_pkg::*, mbox_pkg::*;
();

    localparam int PIN_FUSES    = 0;
    localparam int PIN_UC_RST_B = 1;
    localparam int PIN_AVAIL    = 2;

    logic                        clk;
    logic                        cptra_noncore_rst_b;
    logic [`SOC_IFC_ADDR_W-1:0]  paddr_i;
    logic                        psel_i;
    logic                        penable_i;
    logic                        pwrite_i;
    logic [`SOC_IFC_DATA_W-1:0]  pwdata_i;
    logic                        pready_o;
    logic [`SOC_IFC_DATA_W-1:0]  prdata_o;
    logic                        pslverr_o;
    logic [`SOC_IFC_DATA_W-1:0]  generic_in_i;
    logic [`SOC_IFC_DATA_W-1:0]  generic_out_o;
    logic                        ready_for_fuses_o;
    logic                        ready_for_fw_push_o;
    logic                        ready_for_runtime_o;
    logic                        mailbox_data_avail_o;
    logic                        cptra_uc_rst_b_o;

    int                          errors;
    int                          errors_at_start;
    int                          tests_ok;
    int                          tests_failed;
    logic [`SOC_IFC_DATA_W-1:0]  payload[$];

    soc_ifc_tb_clk i_clk (
        .clk_o (clk)
    );

    soc_ifc_top i_dut (
        .clk                  (clk),
        .cptra_noncore_rst_b  (cptra_noncore_rst_b),
        .paddr_i              (paddr_i),
        .psel_i               (psel_i),
        .penable_i            (penable_i),
        .pwrite_i             (pwrite_i),
        .pwdata_i             (pwdata_i),
        .pready_o             (pready_o),
        .prdata_o             (prdata_o),
        .pslverr_o            (pslverr_o),
        .generic_in_i         (generic_in_i),
        .generic_out_o        (generic_out_o),
        .ready_for_fuses_o    (ready_for_fuses_o),
        .ready_for_fw_push_o  (ready_for_fw_push_o),
        .ready_for_runtime_o  (ready_for_runtime_o),
        .mailbox_data_avail_o (mailbox_data_avail_o),
        .cptra_uc_rst_b_o     (cptra_uc_rst_b_o)
    );

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s expected %h got %h at %0t", name, exp, got, $time);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            tests_ok++;
            $display("%-18s ok", name);
        end else begin
            tests_failed++;
            $display("%-18s failed, %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // One APB transfer sampled at the completing edge
    task automatic apb_xfer(
        input  logic                        is_write,
        input  logic [`SOC_IFC_ADDR_W-1:0]  addr,
        input  logic [`SOC_IFC_DATA_W-1:0]  wdata,
        output logic [`SOC_IFC_DATA_W-1:0]  rdata,
        output logic                        err
    );
        int cycles;
        @(posedge clk);
        paddr_i   <= addr;
        pwrite_i  <= is_write;
        pwdata_i  <= wdata;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge clk);
        penable_i <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!pready_o && cycles < 20);
        if (!pready_o) begin
            $display("APB access to %h saw no pready_o within 20 cycles", addr);
            errors++;
        end
        rdata     = prdata_o;
        err       = pslverr_o;
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic apb_write(
        input  logic [`SOC_IFC_ADDR_W-1:0]  addr,
        input  logic [`SOC_IFC_DATA_W-1:0]  wdata,
        output logic                        err
    );
        logic [`SOC_IFC_DATA_W-1:0] ignored;
        apb_xfer(1'b1, addr, wdata, ignored, err);
    endtask

    task automatic apb_read(
        input  logic [`SOC_IFC_ADDR_W-1:0]  addr,
        output logic [`SOC_IFC_DATA_W-1:0]  rdata,
        output logic                        err
    );
        apb_xfer(1'b0, addr, '0, rdata, err);
    endtask

    function automatic logic pin_value(input int which);
        case (which)
            PIN_FUSES:    pin_value = ready_for_fuses_o;
            PIN_UC_RST_B: pin_value = cptra_uc_rst_b_o;
            default:      pin_value = mailbox_data_avail_o;
        endcase
    endfunction

    task automatic wait_pin(input int which, input logic want, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (pin_value(which) !== want && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (pin_value(which) !== want) begin
            $display("Timed out after %0d cycles waiting for %s", limit, what);
            errors++;
        end
    endtask

    function automatic logic [`SOC_IFC_ADDR_W-1:0] mbox_addr(input mbox_reg_e off);
        return `MBOX_BASE | {4'h0, off};
    endfunction

    task automatic boot_sequence();
        logic [31:0] rdata;
        logic        err;
        wait_pin(PIN_FUSES, 1'b1, 10, "ready_for_fuses_o high after reset");
        check_eq("cptra_uc_rst_b_o", 32'(cptra_uc_rst_b_o), 32'h0);
        apb_read(12'(BOOT_STATUS), rdata, err);
        check_eq("BOOT_STATUS", rdata, 32'(BOOT_FUSE));
        apb_write(12'(FUSE_DONE), 32'h1, err);
        check_eq("pslverr_o", 32'(err), 32'h0);
        wait_pin(PIN_UC_RST_B, 1'b1, 10, "cptra_uc_rst_b_o high after FUSE_DONE");
        check_eq("ready_for_fuses_o", 32'(ready_for_fuses_o), 32'h0);
        apb_read(12'(BOOT_STATUS), rdata, err);
        check_eq("BOOT_STATUS", rdata, 32'(BOOT_DONE));
    endtask

    // Lines hold op, address, write data, expected read data, expected error
    task automatic replay_cases();
        int          fd;
        int          fields;
        string       line;
        string       op;
        logic [11:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic [31:0] rdata;
        logic        exp_err;
        logic        err;
        fd = $fopen("tb/soc_ifc_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/soc_ifc_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h", op, addr, wdata, exp_rdata, exp_err);
            if (fields != 5) begin
                continue;
            end
            if (op == "W") begin
                apb_write(addr, wdata, err);
                check_eq("pslverr_o", 32'(err), 32'(exp_err));
                // Output pins settle one edge after the write
                if (!exp_err && addr == 12'(FLOW_STATUS)) begin
                    @(posedge clk);
                    check_eq("ready_for_fw_push_o", 32'(ready_for_fw_push_o), 32'(wdata[0]));
                    check_eq("ready_for_runtime_o", 32'(ready_for_runtime_o), 32'(wdata[1]));
                end
                if (!exp_err && addr == 12'(GENERIC_OUT)) begin
                    @(posedge clk);
                    check_eq("generic_out_o", generic_out_o, wdata);
                end
            end else begin
                apb_read(addr, rdata, err);
                check_eq("pslverr_o", 32'(err), 32'(exp_err));
                if (!exp_err) begin
                    check_eq("prdata_o", rdata, exp_rdata);
                end
            end
        end
        $fclose(fd);
    endtask

    // Core reset must stay low for wait value plus one cycles
    task automatic fw_reset_check(input int wait_val);
        int   low_cycles;
        int   i;
        logic seen_low;
        logic ended;
        logic err;
        apb_write(12'(FW_UPDATE_WAIT), 32'(wait_val), err);
        check_eq("pslverr_o", 32'(err), 32'h0);
        apb_write(12'(FW_UPDATE_RESET), 32'h1, err);
        check_eq("pslverr_o", 32'(err), 32'h0);
        low_cycles = 0;
        seen_low   = 1'b0;
        ended      = 1'b0;
        for (i = 0; i < 300 && !ended; i++) begin
            @(posedge clk);
            if (!cptra_uc_rst_b_o) begin
                low_cycles++;
                seen_low = 1'b1;
            end else if (seen_low) begin
                ended = 1'b1;
            end
        end
        if (!ended) begin
            $display("Core reset gave no complete low pulse within 300 cycles");
            errors++;
        end else begin
            check_eq("cptra_uc_rst_b_o low cycles", 32'(low_cycles), 32'(wait_val + 1));
        end
    endtask

    task automatic push_words(input int n);
        logic [31:0] word;
        logic        err;
        payload.delete();
        for (int i = 0; i < n; i++) begin
            word = $urandom;
            payload.push_back(word);
            apb_write(mbox_addr(MBOX_DATAIN), word, err);
            check_eq("pslverr_o", 32'(err), 32'h0);
        end
    endtask

    task automatic pop_words();
        logic [31:0] rdata;
        logic        err;
        foreach (payload[i]) begin
            apb_read(mbox_addr(MBOX_DATAOUT), rdata, err);
            check_eq("prdata_o", rdata, payload[i]);
            check_eq("pslverr_o", 32'(err), 32'h0);
        end
    endtask

    task automatic mailbox_errors();
        logic [31:0] rdata;
        logic        err;
        // Idle mailbox takes nothing but a lock read
        apb_write(mbox_addr(MBOX_DATAIN), 32'hdeadbeef, err);
        check_eq("pslverr_o", 32'(err), 32'h1);
        apb_read(mbox_addr(MBOX_DATAOUT), rdata, err);
        check_eq("pslverr_o", 32'(err), 32'h1);
        apb_read(mbox_addr(MBOX_LOCK), rdata, err);
        check_eq("prdata_o", rdata, 32'h0);
        push_words(`MBOX_DEPTH);
        apb_write(mbox_addr(MBOX_DATAIN), $urandom, err);
        check_eq("pslverr_o", 32'(err), 32'h1);
        apb_write(mbox_addr(MBOX_EXECUTE), 32'h1, err);
        check_eq("pslverr_o", 32'(err), 32'h0);
        pop_words();
        apb_read(mbox_addr(MBOX_DATAOUT), rdata, err);
        check_eq("pslverr_o", 32'(err), 32'h1);
        apb_write(mbox_addr(MBOX_EXECUTE), 32'h0, err);
        check_eq("pslverr_o", 32'(err), 32'h0);
    endtask

    task automatic mailbox_flow();
        logic [31:0] rdata;
        logic [31:0] cmd;
        logic        err;
        apb_read(mbox_addr(MBOX_LOCK), rdata, err);
        check_eq("prdata_o", rdata, 32'h0);
        apb_read(mbox_addr(MBOX_LOCK), rdata, err);
        check_eq("prdata_o", rdata, 32'h1);
        cmd = $urandom;
        apb_write(mbox_addr(MBOX_CMD), cmd, err);
        check_eq("pslverr_o", 32'(err), 32'h0);
        push_words(int'($urandom_range(16, 1)));
        apb_write(mbox_addr(MBOX_EXECUTE), 32'h1, err);
        check_eq("pslverr_o", 32'(err), 32'h0);
        wait_pin(PIN_AVAIL, 1'b1, 4, "mailbox_data_avail_o high");
        apb_read(mbox_addr(MBOX_CMD), rdata, err);
        check_eq("MBOX_CMD", rdata, cmd);
        pop_words();
        apb_write(mbox_addr(MBOX_EXECUTE), 32'h0, err);
        check_eq("pslverr_o", 32'(err), 32'h0);
        wait_pin(PIN_AVAIL, 1'b0, 4, "mailbox_data_avail_o low");
        apb_read(mbox_addr(MBOX_LOCK), rdata, err);
        check_eq("prdata_o", rdata, 32'h0);
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        void'($urandom(32'he52d));
        errors              = 0;
        errors_at_start     = 0;
        tests_ok            = 0;
        tests_failed        = 0;
        cptra_noncore_rst_b = 1'b0;
        paddr_i             = '0;
        psel_i              = 1'b0;
        penable_i           = 1'b0;
        pwrite_i            = 1'b0;
        pwdata_i            = '0;
        generic_in_i        = $urandom;

        repeat (8) @(posedge clk);
        check_eq("ready_for_fuses_o", 32'(ready_for_fuses_o), 32'h0);
        check_eq("cptra_uc_rst_b_o", 32'(cptra_uc_rst_b_o), 32'h0);
        check_eq("mailbox_data_avail_o", 32'(mailbox_data_avail_o), 32'h0);
        check_eq("ready_for_fw_push_o", 32'(ready_for_fw_push_o), 32'h0);
        check_eq("ready_for_runtime_o", 32'(ready_for_runtime_o), 32'h0);
        check_eq("pready_o", 32'(pready_o), 32'h0);
        cptra_noncore_rst_b <= 1'b1;
        end_test("reset");

        boot_sequence();
        end_test("boot");
        replay_cases();
        apb_read(12'(GENERIC_IN), rdata, err);
        check_eq("GENERIC_IN", rdata, generic_in_i);
        end_test("registers");
        fw_reset_check(0);
        fw_reset_check(3);
        fw_reset_check(int'($urandom_range(20, 1)));
        end_test("fw update reset");
        mailbox_errors();
        end_test("mailbox errors");
        mailbox_flow();
        end_test("mailbox flow");

        $display("Summary: %0d tests ok, %0d tests failed", tests_ok, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
